//--- rtl/txbd_macros.svh
/* Width, slot count, chunk size and opcode defines for the TX BD engine.
   Included by the package and by any RTL that sizes logic from them. */
`ifndef TXBD_MACROS_SVH
`define TXBD_MACROS_SVH

// slot pool depth, also the BD-in-flight limit
`define TXBD_SLOTS      16
`define TXBD_SLOT_W     4

`define TXBD_LEN_W      32
`define TXBD_ADDR_W     64

// 4 KB read chunks
`define TXBD_CHUNK_W    12
`define TXBD_CMD_LEN_W  13

// opcodes
`define TXBD_OP_READ    2'd1
`define TXBD_OP_WRITE   2'd2

`endif

//--- rtl/txbd_pkg.sv
/* Shared types for the TX BD engine: field vectors, bus structs and the
   intake FSM states. Referenced by scoped name from every RTL file. */
`default_nettype none
`include "txbd_macros.svh"

package txbd_pkg;

    typedef logic [`TXBD_SLOT_W-1:0]    slot_t;
    typedef logic [`TXBD_LEN_W-1:0]     len_t;
    typedef logic [`TXBD_ADDR_W-1:0]    addr_t;
    typedef logic [1:0]                 opcode_t;
    typedef logic [`TXBD_CMD_LEN_W-1:0] cmd_len_t;

    // buffer descriptor as popped from the inbound queue
    typedef struct packed {
        logic [7:0] thread_id;
        opcode_t    opcode;
        len_t       len;
        addr_t      des_addr;
        addr_t      src_addr;
    } bd_t;

    // one chunked read command
    typedef struct packed {
        logic     sod;
        logic     eod;
        opcode_t  opcode;
        slot_t    slot;
        cmd_len_t len;
        addr_t    addr;
    } rd_cmd_t;

    typedef struct packed {
        bd_t   bd;
        slot_t slot;
    } bd_out_t;

    typedef enum logic [1:0] {IDLE, CLAIM, GEN} ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/txbd_ctrl.sv
/* Intake control: pops a BD together with a free slot, writes the BD into
   the store and hands it to the command generator, one BD at a time. */
`timescale 1ns/1ps
`default_nettype none

module txbd_ctrl (
    input  wire                  clk_sys,
    input  wire                  rst,
    input  wire                  inq_empty,
    input  wire txbd_pkg::bd_t   inq_rdata,
    output logic                 inq_rd,
    input  wire                  slot_avail,
    input  wire txbd_pkg::slot_t free_slot,
    output logic                 claim,
    input  wire                  gen_busy,
    output logic                 wr_en,
    output txbd_pkg::slot_t      wr_slot,
    output txbd_pkg::bd_t        wr_bd,
    output logic                 start,
    output txbd_pkg::bd_t        gen_bd,
    output txbd_pkg::slot_t      gen_slot
);

    txbd_pkg::ctrl_state_e state;
    txbd_pkg::bd_t         bd_q;
    txbd_pkg::slot_t       slot_q;

    // pop queue and pool in the same cycle
    assign inq_rd = (state == txbd_pkg::IDLE) && !inq_empty && slot_avail && !gen_busy;
    assign claim  = inq_rd;

    assign wr_en    = (state == txbd_pkg::CLAIM);
    assign start    = (state == txbd_pkg::CLAIM);
    assign wr_slot  = slot_q;
    assign wr_bd    = bd_q;
    assign gen_slot = slot_q;
    assign gen_bd   = bd_q;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            state <= txbd_pkg::IDLE;
        end else begin
            case (state)
                txbd_pkg::IDLE:  if (inq_rd) state <= txbd_pkg::CLAIM;
                txbd_pkg::CLAIM: state <= txbd_pkg::GEN;
                // busy is already up on the first GEN cycle
                txbd_pkg::GEN:   if (!gen_busy) state <= txbd_pkg::IDLE;
                default:         state <= txbd_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (inq_rd) begin
            bd_q   <= inq_rdata;
            slot_q <= free_slot;
        end
    end

endmodule

`default_nettype wire

//--- rtl/txbd_slot_pool.sv
/* Free-slot FIFO. Fills itself with every slot number after reset, then
   hands slots out on claim and takes them back on release. */
`timescale 1ns/1ps
`include "txbd_macros.svh"
`default_nettype none

module txbd_slot_pool (
    input  wire                  clk_sys,
    input  wire                  rst,
    input  wire                  claim,
    input  wire                  rel_en,
    input  wire txbd_pkg::slot_t rel_slot,
    output logic                 slot_avail,
    output txbd_pkg::slot_t      free_slot
);

    txbd_pkg::slot_t         mem [`TXBD_SLOTS];
    txbd_pkg::slot_t         wr_ptr;
    txbd_pkg::slot_t         rd_ptr;
    logic [`TXBD_SLOT_W:0]   count;
    logic [`TXBD_SLOT_W:0]   fill_cnt;
    logic                    fill_done;
    logic                    push;
    txbd_pkg::slot_t         push_slot;

    // fill ends once the counter reaches TXBD_SLOTS
    assign fill_done = fill_cnt[`TXBD_SLOT_W];
    assign push      = !fill_done || rel_en;
    assign push_slot = fill_done ? rel_slot : fill_cnt[`TXBD_SLOT_W-1:0];

    assign slot_avail = fill_done && (count != '0);
    assign free_slot  = mem[rd_ptr];

    always_ff @(posedge clk_sys) begin
        if (push) mem[wr_ptr] <= push_slot;
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            fill_cnt <= '0;
        end else begin
            if (!fill_done) fill_cnt <= fill_cnt + 1'b1;
            if (push)       wr_ptr   <= wr_ptr + 1'b1;
            if (claim)      rd_ptr   <= rd_ptr + 1'b1;
            case ({push, claim})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/txbd_store.sv
/* BD memory indexed by slot number, written at intake and read back on
   completion with one cycle of read latency. */
`timescale 1ns/1ps
`include "txbd_macros.svh"
`default_nettype none

module txbd_store (
    input  wire                  clk_sys,
    input  wire                  wr_en,
    input  wire txbd_pkg::slot_t wr_slot,
    input  wire txbd_pkg::bd_t   wr_bd,
    input  wire txbd_pkg::slot_t rd_slot,
    output txbd_pkg::bd_t        rd_bd
);

    txbd_pkg::bd_t mem [`TXBD_SLOTS];

    always_ff @(posedge clk_sys) begin
        if (wr_en) mem[wr_slot] <= wr_bd;
    end

    // registered read port
    always_ff @(posedge clk_sys) begin
        rd_bd <= mem[rd_slot];
    end

endmodule

`default_nettype wire

//--- rtl/txbd_cmd_gen.sv
/* Splits one BD into 4 KB read commands with sod/eod markers, issuing one
   per cycle while the command sink is not full. busy covers the whole BD. */
`timescale 1ns/1ps
`include "txbd_macros.svh"
`default_nettype none

module txbd_cmd_gen (
    input  wire                  clk_sys,
    input  wire                  rst,
    input  wire                  start,
    input  wire txbd_pkg::bd_t   bd,
    input  wire txbd_pkg::slot_t slot,
    input  wire                  cmd_full,
    output logic                 cmd_wr,
    output txbd_pkg::rd_cmd_t    cmd,
    output logic                 busy
);

    localparam txbd_pkg::len_t CHUNK = txbd_pkg::len_t'(1) << `TXBD_CHUNK_W;

    txbd_pkg::len_t    rem;
    txbd_pkg::addr_t   addr;
    logic              first;
    txbd_pkg::opcode_t op_q;
    txbd_pkg::slot_t   slot_q;
    logic              last;

    // also covers zero length and read BDs (rem loaded as 0)
    assign last   = (rem <= CHUNK);
    assign cmd_wr = busy && !cmd_full;

    always_comb begin
        cmd        = '0;
        cmd.sod    = first;
        cmd.eod    = last;
        cmd.opcode = op_q;
        cmd.slot   = slot_q;
        cmd.len    = last ? txbd_pkg::cmd_len_t'(rem) : txbd_pkg::cmd_len_t'(CHUNK);
        cmd.addr   = addr;
    end

    //----------------------------------------------------------------------
    // control
    //----------------------------------------------------------------------
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            first <= 1'b0;
        end else if (start) begin
            busy  <= 1'b1;
            first <= 1'b1;
        end else if (cmd_wr) begin
            first <= 1'b0;
            if (last) busy <= 1'b0;
        end
    end

    //----------------------------------------------------------------------
    // length and address walk
    //----------------------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (start) begin
            // read BDs fetch no payload
            rem    <= (bd.opcode == `TXBD_OP_READ) ? '0 : bd.len;
            addr   <= bd.src_addr;
            op_q   <= bd.opcode;
            slot_q <= slot;
        end else if (cmd_wr && !last) begin
            rem  <= rem - CHUNK;
            addr <= addr + txbd_pkg::addr_t'(CHUNK);
        end
    end

endmodule

`default_nettype wire

//--- rtl/txbd_cpl.sv
/* Completion path: queues completed slots, reads their BDs back from the
   store, routes them by opcode and returns each slot to the pool. */
`timescale 1ns/1ps
`include "txbd_macros.svh"
`default_nettype none

module txbd_cpl (
    input  wire                  clk_sys,
    input  wire                  rst,
    input  wire                  rsp_wr,
    input  wire txbd_pkg::slot_t rsp_slot,
    input  wire                  kernel_afull,
    input  wire                  rx_afull,
    output txbd_pkg::slot_t      rd_slot,
    input  wire txbd_pkg::bd_t   rd_bd,
    output logic                 rel_en,
    output txbd_pkg::slot_t      rel_slot,
    output logic                 kernel_wen,
    output logic                 rx_wen,
    output txbd_pkg::bd_out_t    bd_out
);

    txbd_pkg::slot_t       fifo [`TXBD_SLOTS];
    txbd_pkg::slot_t       wr_ptr;
    txbd_pkg::slot_t       rd_ptr;
    logic [`TXBD_SLOT_W:0] count;
    logic                  pop;
    logic                  s1_valid;
    txbd_pkg::slot_t       s1_slot;
    logic                  to_rx;

    // either sink near full holds off new pops
    assign pop      = (count != '0) && !kernel_afull && !rx_afull;
    assign rd_slot  = fifo[rd_ptr];
    assign rel_en   = pop;
    assign rel_slot = fifo[rd_ptr];

    always_ff @(posedge clk_sys) begin
        if (rsp_wr) fifo[wr_ptr] <= rsp_slot;
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rsp_wr) wr_ptr <= wr_ptr + 1'b1;
            if (pop)    rd_ptr <= rd_ptr + 1'b1;
            case ({rsp_wr, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // stage 1 waits on the store read, stage 2 drives the sinks
    //----------------------------------------------------------------------
    // read and write BDs go to the rx path
    assign to_rx = (rd_bd.opcode == `TXBD_OP_READ) || (rd_bd.opcode == `TXBD_OP_WRITE);

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            kernel_wen <= 1'b0;
            rx_wen     <= 1'b0;
        end else begin
            s1_valid   <= pop;
            kernel_wen <= s1_valid && !to_rx;
            rx_wen     <= s1_valid && to_rx;
        end
    end

    always_ff @(posedge clk_sys) begin
        s1_slot     <= rd_slot;
        bd_out.bd   <= rd_bd;
        bd_out.slot <= s1_slot;
    end

endmodule

`default_nettype wire

//--- rtl/txbd_top.sv
/* TX BD engine top level. Connects intake control, slot pool, BD store,
   command generator and completion path. */
`timescale 1ns/1ps
`default_nettype none

module txbd_top (
    input  wire                  clk_sys,
    input  wire                  rst,
    // inbound BD queue
    input  wire                  inq_empty,
    input  wire txbd_pkg::bd_t   inq_rdata,
    output logic                 inq_rd,
    // read commands
    input  wire                  cmd_full,
    output logic                 cmd_wr,
    output txbd_pkg::rd_cmd_t    cmd,
    // completions
    input  wire                  rsp_wr,
    input  wire txbd_pkg::slot_t rsp_slot,
    // BD sinks
    input  wire                  kernel_afull,
    input  wire                  rx_afull,
    output logic                 kernel_wen,
    output logic                 rx_wen,
    output txbd_pkg::bd_out_t    bd_out
);

    logic            slot_avail;
    txbd_pkg::slot_t free_slot;
    logic            claim;
    logic            gen_busy;
    logic            wr_en;
    txbd_pkg::slot_t wr_slot;
    txbd_pkg::bd_t   wr_bd;
    logic            start;
    txbd_pkg::bd_t   gen_bd;
    txbd_pkg::slot_t gen_slot;
    txbd_pkg::slot_t rd_slot;
    txbd_pkg::bd_t   rd_bd;
    logic            rel_en;
    txbd_pkg::slot_t rel_slot;

    txbd_ctrl u_ctrl (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .inq_empty  (inq_empty),
        .inq_rdata  (inq_rdata),
        .inq_rd     (inq_rd),
        .slot_avail (slot_avail),
        .free_slot  (free_slot),
        .claim      (claim),
        .gen_busy   (gen_busy),
        .wr_en      (wr_en),
        .wr_slot    (wr_slot),
        .wr_bd      (wr_bd),
        .start      (start),
        .gen_bd     (gen_bd),
        .gen_slot   (gen_slot)
    );

    txbd_slot_pool u_pool (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .claim      (claim),
        .rel_en     (rel_en),
        .rel_slot   (rel_slot),
        .slot_avail (slot_avail),
        .free_slot  (free_slot)
    );

    txbd_store u_store (
        .clk_sys (clk_sys),
        .wr_en   (wr_en),
        .wr_slot (wr_slot),
        .wr_bd   (wr_bd),
        .rd_slot (rd_slot),
        .rd_bd   (rd_bd)
    );

    txbd_cmd_gen u_cmd_gen (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .start    (start),
        .bd       (gen_bd),
        .slot     (gen_slot),
        .cmd_full (cmd_full),
        .cmd_wr   (cmd_wr),
        .cmd      (cmd),
        .busy     (gen_busy)
    );

    txbd_cpl u_cpl (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .rsp_wr       (rsp_wr),
        .rsp_slot     (rsp_slot),
        .kernel_afull (kernel_afull),
        .rx_afull     (rx_afull),
        .rd_slot      (rd_slot),
        .rd_bd        (rd_bd),
        .rel_en       (rel_en),
        .rel_slot     (rel_slot),
        .kernel_wen   (kernel_wen),
        .rx_wen       (rx_wen),
        .bd_out       (bd_out)
    );

endmodule

`default_nettype wire

//--- verif/txbd_chk.sv
/* Handshake assertions on the TX BD engine ports, bound into txbd_top. */
`timescale 1ns/1ps
`default_nettype none

module txbd_chk (
    input wire clk_sys,
    input wire rst,
    input wire inq_empty,
    input wire inq_rd,
    input wire cmd_full,
    input wire cmd_wr,
    input wire kernel_wen,
    input wire rx_wen
);

    int err_cnt = 0;

    // command sink back-pressure
    cmd_hold: assert property (@(posedge clk_sys) disable iff (rst) !(cmd_wr && cmd_full))
        else begin
            err_cnt++;
            $error("cmd_wr high while cmd_full high");
        end

    pop_guard: assert property (@(posedge clk_sys) disable iff (rst) !(inq_rd && inq_empty))
        else begin
            err_cnt++;
            $error("inq_rd high while inq_empty high");
        end

    // a BD goes to exactly one sink
    one_sink: assert property (@(posedge clk_sys) disable iff (rst) !(kernel_wen && rx_wen))
        else begin
            err_cnt++;
            $error("kernel_wen and rx_wen high together");
        end

endmodule

bind txbd_top txbd_chk u_chk (
    .clk_sys    (clk_sys),
    .rst        (rst),
    .inq_empty  (inq_empty),
    .inq_rd     (inq_rd),
    .cmd_full   (cmd_full),
    .cmd_wr     (cmd_wr),
    .kernel_wen (kernel_wen),
    .rx_wen     (rx_wen)
);

`default_nettype wire

//--- verif/txbd_tb.sv
/* Testbench for the TX BD engine. Drives LFSR-made BDs and back-pressure,
   expands each BD into its expected commands and answers completions. */
`timescale 1ns/1ps
`include "txbd_macros.svh"
`default_nettype none

module txbd_tb;

    localparam int N_BD  = 40;
    localparam int CHUNK = 1 << `TXBD_CHUNK_W;

    logic              clk_sys = 1'b0;
    logic              rst;
    logic              inq_empty;
    txbd_pkg::bd_t     inq_rdata;
    logic              inq_rd;
    logic              cmd_full;
    logic              cmd_wr;
    txbd_pkg::rd_cmd_t cmd;
    logic              rsp_wr;
    txbd_pkg::slot_t   rsp_slot;
    logic              kernel_afull;
    logic              rx_afull;
    logic              kernel_wen;
    logic              rx_wen;
    txbd_pkg::bd_out_t bd_out;

    logic [31:0]       lfsr;
    txbd_pkg::bd_t     bd_list [N_BD];
    txbd_pkg::bd_t     slot_bd [`TXBD_SLOTS];
    logic              in_flight [`TXBD_SLOTS];
    txbd_pkg::rd_cmd_t exp_cmds [$];
    txbd_pkg::bd_t     bd_fifo [$];
    txbd_pkg::slot_t   rsp_pend [$];
    txbd_pkg::slot_t   out_exp [$];
    txbd_pkg::slot_t   cur_slot;
    txbd_pkg::bd_t     cur_bd;
    int                n_pop;
    int                n_out;
    int                n_exp_total;
    int                cyc;
    int                rsp_budget;
    int                rsp_delay;
    int                n_chk;
    int                n_mis;
    int                n_oth;

    txbd_top u_dut (.*);

    initial begin
        forever #10 clk_sys = ~clk_sys;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    //----------------------------------------------------------------------
    // reference model of the chunk split
    //----------------------------------------------------------------------
    function automatic int cmd_count(input txbd_pkg::bd_t bd);
        if (bd.opcode == `TXBD_OP_READ || bd.len == '0) return 1;
        return int'((bd.len - 32'd1) >> `TXBD_CHUNK_W) + 1;
    endfunction

    // slot stays 0 until the DUT picks one
    function automatic txbd_pkg::rd_cmd_t ref_cmd(input txbd_pkg::bd_t bd, input int idx);
        txbd_pkg::rd_cmd_t c;
        int                n;
        n        = cmd_count(bd);
        c        = '0;
        c.sod    = (idx == 0);
        c.eod    = (idx == n - 1);
        c.opcode = bd.opcode;
        c.addr   = bd.src_addr + 64'(idx) * 64'(CHUNK);
        if (bd.opcode == `TXBD_OP_READ) c.len = '0;
        else if (idx < n - 1) c.len = 13'(CHUNK);
        else c.len = 13'(bd.len - 32'(n - 1) * 32'(CHUNK));
        return c;
    endfunction

    task automatic report_error(input string msg);
        n_oth++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic report_mismatch(input string name, input logic [255:0] exp,
                                   input logic [255:0] act);
        n_mis++;
        $display("mismatch %s at %0t: expected %0h, actual %0h", name, $time, exp, act);
    endtask

    task automatic compare_cmd();
        txbd_pkg::rd_cmd_t exp;
        if (exp_cmds.size() == 0) begin
            report_error("command issued with no BD outstanding");
            return;
        end
        exp = exp_cmds.pop_front();
        if (exp.sod) begin
            cur_slot = cmd.slot;
            cur_bd   = bd_fifo.pop_front();
            if (in_flight[cur_slot])
                report_error($sformatf("slot %0d claimed while still in flight", cur_slot));
            in_flight[cur_slot] = 1'b1;
        end
        exp.slot = cur_slot;
        n_chk++;
        if (cmd !== exp)
            report_mismatch((exp.opcode == `TXBD_OP_READ) ? "read_cmd" : "chunk_cmd",
                            256'(exp), 256'(cmd));
        if (exp.eod) begin
            slot_bd[cur_slot] = cur_bd;
            rsp_pend.push_back(cur_slot);
        end
    endtask

    task automatic verify_bd_out();
        txbd_pkg::slot_t s;
        logic            exp_rx;
        n_out++;
        if (out_exp.size() == 0) begin
            report_error("BD output with no completion outstanding");
            return;
        end
        s            = out_exp.pop_front();
        exp_rx       = (slot_bd[s].opcode == `TXBD_OP_READ) ||
                       (slot_bd[s].opcode == `TXBD_OP_WRITE);
        in_flight[s] = 1'b0;
        n_chk        = n_chk + 3;
        if (bd_out.slot !== s) report_mismatch("out_slot", 256'(s), 256'(bd_out.slot));
        if (bd_out.bd !== slot_bd[s]) report_mismatch("out_bd", 256'(slot_bd[s]), 256'(bd_out.bd));
        if (rx_wen !== exp_rx) report_mismatch("out_route", 256'(exp_rx), 256'(rx_wen));
    endtask

    //----------------------------------------------------------------------
    // monitor and comparison on the rising edge
    //----------------------------------------------------------------------
    always @(posedge clk_sys) begin
        if (rst) cyc = 0;
        else cyc++;
        if ((rst || cyc <= `TXBD_SLOTS) && (inq_rd || cmd_wr || kernel_wen || rx_wen))
            report_error("DUT output active during reset or slot pool fill");
        if (!rst) begin
            if (kernel_wen || rx_wen) verify_bd_out();
            if (cmd_wr) compare_cmd();
            if (rsp_wr) out_exp.push_back(rsp_slot);
            if (inq_rd && n_pop >= N_BD) begin
                report_error("BD popped from an empty queue");
            end else if (inq_rd) begin
                for (int i = 0; i < cmd_count(bd_list[n_pop]); i++)
                    exp_cmds.push_back(ref_cmd(bd_list[n_pop], i));
                bd_fifo.push_back(bd_list[n_pop]);
                n_pop++;
            end
        end
    end

    // inputs change on the falling edge only
    always @(negedge clk_sys) begin
        inq_empty = (n_pop >= N_BD);
        if (n_pop < N_BD) inq_rdata = bd_list[n_pop];
        cmd_full     = (rand_bits(2) == 32'd3);
        kernel_afull = (rand_bits(3) == 32'd0);
        rx_afull     = (rand_bits(3) == 32'd0);
        rsp_wr       = 1'b0;
        if (rsp_pend.size() != 0 && rsp_budget > 0) begin
            if (rsp_delay == 0) begin
                rsp_wr     = 1'b1;
                rsp_slot   = rsp_pend.pop_front();
                rsp_budget = rsp_budget - 1;
                rsp_delay  = int'(rand_bits(3));
            end else begin
                rsp_delay = rsp_delay - 1;
            end
        end
    end

    initial begin
        #1;
        repeat (16 + 40 * n_exp_total + 200 * N_BD) @(posedge clk_sys);
        $display("error: watchdog expired with %0d BDs popped and %0d BDs out", n_pop, n_out);
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 n_chk, n_mis, n_oth + 1, u_dut.u_chk.err_cnt);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial begin
        txbd_pkg::bd_t b;
        int            sel;
        lfsr       = 32'ha1fc_532b;
        rsp_budget = 0;
        rsp_delay  = 0;
        for (int k = 0; k < N_BD; k++) begin
            b.thread_id       = 8'(rand_bits(8));
            b.opcode          = 2'(rand_bits(2));
            sel               = int'(rand_bits(2));
            if (sel == 0) b.len = rand_bits(4);
            else if (sel == 1) b.len = 32'(CHUNK) * (rand_bits(2) + 32'd1);
            else b.len = rand_bits(15) % 32'd20000;
            b.des_addr[63:32] = rand_bits(32);
            b.des_addr[31:0]  = rand_bits(32);
            b.src_addr[63:32] = rand_bits(32);
            b.src_addr[31:0]  = rand_bits(32);
            bd_list[k]        = b;
            n_exp_total       = n_exp_total + cmd_count(b);
        end
        for (int s = 0; s < `TXBD_SLOTS; s++) in_flight[s] = 1'b0;
        rst          = 1'b1;
        inq_empty    = 1'b0;
        inq_rdata    = bd_list[0];
        cmd_full     = 1'b0;
        rsp_wr       = 1'b0;
        rsp_slot     = '0;
        kernel_afull = 1'b0;
        rx_afull     = 1'b0;
        repeat (16) @(negedge clk_sys);
        rst = 1'b0;

        // without completions intake stops once every slot is taken
        while (n_pop < `TXBD_SLOTS || exp_cmds.size() != 0) @(negedge clk_sys);
        repeat (100) @(negedge clk_sys);
        n_chk++;
        if (n_pop != `TXBD_SLOTS)
            report_error($sformatf("%0d BDs popped with all slots in flight", n_pop));

        @(posedge clk_sys);
        rsp_budget = 1;
        while (n_pop < `TXBD_SLOTS + 1 || exp_cmds.size() != 0) @(negedge clk_sys);
        repeat (100) @(negedge clk_sys);
        n_chk++;
        if (n_pop != `TXBD_SLOTS + 1 || n_out != 1)
            report_error($sformatf("one completion gave %0d pops and %0d outputs",
                                   n_pop - `TXBD_SLOTS, n_out));

        @(posedge clk_sys);
        rsp_budget = 1000000;
        while (n_out < N_BD) @(negedge clk_sys);
        repeat (50) @(negedge clk_sys);
        n_chk++;
        if (n_pop != N_BD || n_out != N_BD || exp_cmds.size() != 0 || out_exp.size() != 0)
            report_error($sformatf("end of run with %0d BDs popped and %0d BDs out",
                                   n_pop, n_out));

        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 n_chk, n_mis, n_oth, u_dut.u_chk.err_cnt);
        if (n_mis == 0 && n_oth == 0 && u_dut.u_chk.err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+rtl
rtl/txbd_pkg.sv
rtl/txbd_ctrl.sv
rtl/txbd_slot_pool.sv
rtl/txbd_store.sv
rtl/txbd_cmd_gen.sv
rtl/txbd_cpl.sv
rtl/txbd_top.sv
verif/txbd_chk.sv
verif/txbd_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := txbd_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
